//--- src/icache_pkg.sv
package icache_pkg;

	// cache geometry
	localparam int num_ways = 4;
	localparam int num_sets = 16;
	localparam int tag_bits = 22;
	localparam int beats_per_line = 8;
	localparam int rows_per_way = 64;
	// row index width of one line sram
	localparam int row_bits = $clog2(rows_per_way);

	// read burst fields, one line per burst
	localparam logic [7:0] axi_len_line = 8'd7;
	// 8 bytes per beat
	localparam logic [2:0] axi_size_dword = 3'b011;
	localparam logic [1:0] axi_burst_incr = 2'b01;

	// fetch address, read as tag/set/offset for lookup
	// and as row/word for sram access and word select
	typedef union packed {
		struct packed {
			logic [21:0] tag;
			logic [3:0] set;
			logic [5:0] offset;
		} lookup;
		struct packed {
			logic [21:0] upper;
			logic [5:0] row;
			// instruction within the 128-bit row
			logic [1:0] word;
			logic [1:0] byte_off;
		} store;
	} fetch_addr_u;

endpackage

//--- src/sram_port_if.sv
`timescale 1ns/1ps

// shared request lines of the four line srams
interface sram_port_if #(
	parameter int num_ways = icache_pkg::num_ways
);
	import icache_pkg::*;

	// one enable per way, enabled way acts on next edge
	logic [num_ways-1:0] en;
	logic we;
	// set bit = write that bit
	logic [127:0] bwe;
	logic [row_bits-1:0] row;
	logic [127:0] wdata;

	// controller side
	modport ctrl (output en, we, bwe, row, wdata);

	// memory side
	modport mem (input en, we, bwe, row, wdata);

endinterface

//--- src/line_sram.sv
`timescale 1ns/1ps

// behavioural single-port line memory, one way
module line_sram #(
	parameter int way_sel = 0,
	parameter int num_sets = icache_pkg::num_sets
) (
	input logic clk,
	sram_port_if.mem mem,
	output logic [127:0] dout
);
	import icache_pkg::*;

	// four 16-byte rows per 64-byte line
	localparam int depth = num_sets * beats_per_line / 2;

	logic [127:0] cells [depth];
	logic sel;

	// this way addressed in the current cycle
	assign sel = mem.en[way_sel];

	always_ff @(posedge clk) begin
		if (sel) begin
			if (mem.we) begin
				// masked write, only the selected half changes
				cells[mem.row] <= (cells[mem.row] & ~mem.bwe) | (mem.wdata & mem.bwe);
			end else begin
				// registered read
				dout <= cells[mem.row];
			end
		end
	end

endmodule

//--- src/tag_store.sv
`timescale 1ns/1ps

// per-way tag and valid arrays with parallel compare
module tag_store #(
	parameter int num_ways = icache_pkg::num_ways,
	parameter int num_sets = icache_pkg::num_sets,
	parameter int tag_bits = icache_pkg::tag_bits
) (
	input logic clk,
	input logic rst,
	input icache_pkg::fetch_addr_u lookup_addr,
	input logic fill,
	input icache_pkg::fetch_addr_u fill_addr,
	input logic [num_ways-1:0] victim,
	input logic inval,
	input logic [31:0] inval_addr,
	output logic [num_ways-1:0] hit_way
);
	import icache_pkg::*;

	logic [tag_bits-1:0] tag_q [num_ways][num_sets];
	logic [num_sets-1:0] valid_q [num_ways];
	fetch_addr_u inv_u;
	logic [num_ways-1:0] inval_match;
	logic fill_killed;

	assign inv_u = inval_addr;

	// lookup, all ways at once
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			hit_way[w] = valid_q[w][lookup_addr.lookup.set] &&
				(tag_q[w][lookup_addr.lookup.set] == lookup_addr.lookup.tag);
		end
	end

	// store address against resident lines
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			inval_match[w] = valid_q[w][inv_u.lookup.set] &&
				(tag_q[w][inv_u.lookup.set] == inv_u.lookup.tag);
		end
	end

	// store to the very line being filled, fill must not go valid
	assign fill_killed = inval && (fill_addr.lookup.tag == inv_u.lookup.tag) &&
		(fill_addr.lookup.set == inv_u.lookup.set);

	// valid bits, invalidate has the last word
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < num_ways; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < num_ways; w++) begin
				if (fill && victim[w]) begin
					valid_q[w][fill_addr.lookup.set] <= !fill_killed;
				end
				if (inval && inval_match[w]) begin
					valid_q[w][inv_u.lookup.set] <= 1'b0;
				end
			end
		end
	end

	// tags, written with the last beat
	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (fill && victim[w]) begin
				tag_q[w][fill_addr.lookup.set] <= fill_addr.lookup.tag;
			end
		end
	end

	// a line is never resident in two ways
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way))
		else $error("tag_store: hit_way %b not one-hot", hit_way);

endmodule

//--- src/refill_ctrl.sv
`timescale 1ns/1ps

// idle/refill fsm, read address channel and sram requests
module refill_ctrl #(
	parameter int num_ways = icache_pkg::num_ways
) (
	input logic clk,
	input logic rst,
	input icache_pkg::fetch_addr_u addr,
	input logic valid,
	input logic [num_ways-1:0] hit_way,
	input logic arready,
	input logic [63:0] rdata,
	input logic rlast,
	input logic rvalid,
	output logic [31:0] araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	output logic rready,
	output logic fill,
	output icache_pkg::fetch_addr_u fill_addr,
	output logic [num_ways-1:0] victim,
	output logic accept,
	sram_port_if.ctrl sram
);
	import icache_pkg::*;

	localparam logic st_idle = 1'b0;
	localparam logic st_refill = 1'b1;
	localparam int beat_bits = $clog2(beats_per_line);

	logic state_q;
	logic [beat_bits-1:0] beat_q;
	logic [num_ways-1:0] rotor_q;
	fetch_addr_u line_q;
	logic idle;

	assign idle = (state_q == st_idle);

	// hit answered from sram, miss asks the bus
	assign accept = idle && valid && (hit_way != '0);
	assign arvalid = idle && valid && (hit_way == '0);

	// line-aligned burst
	assign araddr = {addr.lookup.tag, addr.lookup.set, 6'b0};
	assign arlen = axi_len_line;
	assign arsize = axi_size_dword;
	assign arburst = axi_burst_incr;
	// beats never stalled
	assign rready = 1'b1;

	// tag update with the last beat
	assign fill = !idle && rvalid && rlast;
	assign fill_addr = line_q;
	assign victim = rotor_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_idle;
			beat_q <= '0;
			rotor_q <= num_ways'(1);
		end else if (idle) begin
			beat_q <= '0;
			// rotor only moves while idle
			rotor_q <= {rotor_q[num_ways-2:0], rotor_q[num_ways-1]};
			if (arvalid && arready) begin
				state_q <= st_refill;
			end
		end else if (rvalid) begin
			beat_q <= beat_q + 1'b1;
			if (rlast) begin
				state_q <= st_idle;
			end
		end
	end

	// line address kept for the whole burst
	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			line_q <= addr;
		end
	end

	// sram request, read of the hit way or beat write into the victim
	always_comb begin
		if (idle) begin
			sram.en = hit_way & {num_ways{valid}};
			sram.we = 1'b0;
			sram.row = addr.store.row;
		end else begin
			sram.en = victim & {num_ways{rvalid}};
			sram.we = rvalid;
			// two beats per row
			sram.row = {line_q.lookup.set, beat_q[beat_bits-1:1]};
		end
		// even beat low half, odd beat high half
		sram.bwe = beat_q[0] ? {{64{1'b1}}, {64{1'b0}}} : {{64{1'b0}}, {64{1'b1}}};
		sram.wdata = {2{rdata}};
	end

	// memory only answers an accepted burst
	a_rvalid_in_refill: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> state_q == st_refill)
		else $error("refill_ctrl: rvalid outside refill");

	// burst ends after exactly one line
	a_rlast_count: assert property (@(posedge clk) disable iff (rst)
		rvalid && rlast |-> beat_q == beat_bits'(beats_per_line - 1))
		else $error("refill_ctrl: rlast on beat %0d", beat_q);

endmodule

//--- src/hit_return.sv
`timescale 1ns/1ps

// answer stage, one cycle after an accepted hit
module hit_return #(
	parameter int num_ways = icache_pkg::num_ways
) (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic accept,
	input icache_pkg::fetch_addr_u addr,
	input logic [num_ways-1:0] hit_way,
	input logic [127:0] dout0,
	input logic [127:0] dout1,
	input logic [127:0] dout2,
	input logic [127:0] dout3,
	output logic [31:0] inst,
	output logic ready,
	output logic hit
);

	logic [num_ways-1:0] way_q;
	logic [1:0] word_q;
	logic [3:0][127:0] dout_all;
	logic [127:0] row_sel;

	assign dout_all = {dout3, dout2, dout1, dout0};

	// level for the fetch stage
	assign hit = accept;

	// flush drops a pending answer
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ready <= 1'b0;
			way_q <= '0;
		end else begin
			ready <= accept;
			way_q <= accept ? hit_way : '0;
		end
	end

	// word select follows the accepted address
	always_ff @(posedge clk) begin
		if (accept) begin
			word_q <= addr.store.word;
		end
	end

	// one-hot way mux, zero when nothing pending
	always_comb begin
		row_sel = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (way_q[w]) begin
				row_sel = row_sel | dout_all[w];
			end
		end
	end

	assign inst = row_sel[{word_q, 5'b0} +: 32];

endmodule

//--- src/icache.sv
`timescale 1ns/1ps

// 4-way instruction cache, top level
module icache #(
	parameter int num_ways = icache_pkg::num_ways,
	parameter int num_sets = icache_pkg::num_sets,
	parameter int tag_bits = icache_pkg::tag_bits
) (
	input logic clk,
	input logic rst,
	// fetch stage
	input logic [31:0] addr,
	input logic valid,
	input logic flush,
	output logic [31:0] inst,
	output logic ready,
	output logic hit,
	// store address from memory stage
	input logic inval,
	input logic [31:0] inval_addr,
	// axi read
	output logic [31:0] araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input logic arready,
	input logic [63:0] rdata,
	// response code accepted, not checked
	input logic [1:0] rresp,
	input logic rlast,
	input logic rvalid,
	output logic rready
);
	import icache_pkg::*;

	fetch_addr_u addr_u;
	fetch_addr_u fill_addr;
	logic [num_ways-1:0] hit_way;
	logic [num_ways-1:0] victim;
	logic fill;
	logic accept;
	logic [127:0] dout [num_ways];

	assign addr_u = addr;

	sram_port_if #(.num_ways(num_ways)) sram_bus ();

	tag_store #(.num_ways(num_ways), .num_sets(num_sets), .tag_bits(tag_bits)) tags_i (
		.clk, .rst, .lookup_addr(addr_u), .fill, .fill_addr, .victim,
		.inval, .inval_addr, .hit_way
	);

	refill_ctrl #(.num_ways(num_ways)) ctrl_i (
		.clk, .rst, .addr(addr_u), .valid, .hit_way, .arready, .rdata, .rlast, .rvalid,
		.araddr, .arlen, .arsize, .arburst, .arvalid, .rready,
		.fill, .fill_addr, .victim, .accept, .sram(sram_bus.ctrl)
	);

	hit_return #(.num_ways(num_ways)) ret_i (
		.clk, .rst, .flush, .accept, .addr(addr_u), .hit_way,
		.dout0(dout[0]), .dout1(dout[1]), .dout2(dout[2]), .dout3(dout[3]),
		.inst, .ready, .hit
	);

	// one line memory per way
	for (genvar w = 0; w < num_ways; w++) begin : g_way
		line_sram #(.way_sel(w), .num_sets(num_sets)) sram_i (
			.clk, .mem(sram_bus.mem), .dout(dout[w])
		);
	end

endmodule

//--- test/axi_mem_model.sv
`timescale 1ns/1ps

// axi read slave, one burst at a time, data computed from the address
module axi_mem_model (
	input logic clk,
	input logic rst,
	input logic [31:0] araddr,
	input logic [7:0] arlen,
	input logic [2:0] arsize,
	input logic [1:0] arburst,
	input logic arvalid,
	output logic arready,
	output logic [63:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready,
	output int proto_errors
);
	import icache_pkg::*;

	int err_cnt = 0;
	logic [31:0] rng_q;
	logic [31:0] base_q;
	logic [7:0] len_q;
	logic [7:0] beat_q;
	logic [1:0] wait_cnt;
	logic waiting;
	logic busy;
	// bus values taken at the clock edge
	logic rst_s;
	logic arvalid_s;
	logic [31:0] araddr_s;
	logic [7:0] arlen_s;
	logic ar_hs;
	logic r_hs;

	assign proto_errors = err_cnt;

	// instruction word held at byte address a
	function automatic logic [31:0] code_word(input logic [31:0] a);
		return {a[18:0], a[31:19]} ^ 32'h3c5a_e147;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// current beat, lower address in the low half
	task automatic drive_beat();
		logic [31:0] a;
		a = base_q + {21'b0, beat_q, 3'b000};
		rdata = {code_word(a + 32'd4), code_word(a)};
		rlast = (beat_q == len_q);
		rvalid = 1'b1;
	endtask

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		// response always okay
		rresp = 2'b00;
		busy = 1'b0;
		waiting = 1'b0;
		wait_cnt = '0;
		beat_q = '0;
		len_q = '0;
		base_q = '0;
		rng_q = 32'h04cc_91d6;
		forever begin
			@(posedge clk);
			rst_s = rst;
			arvalid_s = arvalid;
			araddr_s = araddr;
			arlen_s = arlen;
			ar_hs = arvalid && arready;
			r_hs = rvalid && rready;
			// outputs move a little after the edge
			#5;
			if (rst_s) begin
				arready = 1'b0;
				rvalid = 1'b0;
				rlast = 1'b0;
				busy = 1'b0;
				waiting = 1'b0;
			end else if (!busy) begin
				if (ar_hs) begin
					arready = 1'b0;
					busy = 1'b1;
					base_q = araddr_s;
					len_q = arlen_s;
					beat_q = '0;
					drive_beat();
				end else if (arvalid_s && !arready) begin
					// new request, draw 0..3 cycles of arready delay
					if (!waiting) begin
						rng_q = xorshift32(rng_q);
						wait_cnt = rng_q[1:0];
						waiting = 1'b1;
					end
					if (wait_cnt == 2'd0) begin
						arready = 1'b1;
						waiting = 1'b0;
					end else begin
						wait_cnt = wait_cnt - 2'd1;
					end
				end
			end else if (r_hs) begin
				if (rlast) begin
					rvalid = 1'b0;
					rlast = 1'b0;
					busy = 1'b0;
				end else begin
					beat_q = beat_q + 8'd1;
					drive_beat();
				end
			end
		end
	end

	// burst shape of a line refill
	a_arlen: assert property (@(posedge clk) disable iff (rst) arvalid |-> arlen == axi_len_line)
		else begin
			err_cnt++;
			$display("FAIL %0t arlen expected %h got %h", $time, axi_len_line, $sampled(arlen));
		end
	a_arsize: assert property (@(posedge clk) disable iff (rst)
		arvalid |-> arsize == axi_size_dword)
		else begin
			err_cnt++;
			$display("FAIL %0t arsize expected %h got %h", $time, axi_size_dword, $sampled(arsize));
		end
	a_arburst: assert property (@(posedge clk) disable iff (rst)
		arvalid |-> arburst == axi_burst_incr)
		else begin
			err_cnt++;
			$display("FAIL %0t arburst expected %h got %h", $time, axi_burst_incr,
				$sampled(arburst));
		end

endmodule

//--- test/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
	import icache_pkg::*;

	// what the first cycle of a fetch must show
	localparam int mode_any = 0;
	localparam int mode_hit = 1;
	localparam int mode_miss = 2;
	// cycle limit for one fetch including its refill
	localparam int fetch_limit = 100;

	logic clk;
	logic rst;
	logic [31:0] addr;
	logic valid;
	logic flush;
	logic [31:0] inst;
	logic ready;
	logic hit;
	logic inval;
	logic [31:0] inval_addr;
	logic [31:0] araddr;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;
	logic [63:0] rdata;
	logic [1:0] rresp;
	logic rlast;
	logic rvalid;
	logic rready;

	int errors = 0;
	int mem_errors;
	bit timed_out = 1'b0;
	logic first;
	int expect_mode;
	logic probing;
	logic probe_done;
	int probe_hits;
	logic [31:0] acc_addr;
	logic exp_ready;
	logic ar_waiting;
	logic [31:0] ar_prev;

	icache #(.num_ways(num_ways), .num_sets(num_sets), .tag_bits(tag_bits)) dut_i (
		.clk, .rst, .addr, .valid, .flush, .inst, .ready, .hit, .inval, .inval_addr,
		.araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
		.rdata, .rresp, .rlast, .rvalid, .rready
	);

	axi_mem_model mem_i (
		.clk, .rst, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
		.rdata, .rresp, .rlast, .rvalid, .rready, .proto_errors(mem_errors)
	);

	// expected instruction at byte address a
	function automatic logic [31:0] code_word(input logic [31:0] a);
		return {a[18:0], a[31:19]} ^ 32'h3c5a_e147;
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// accepted address, due answer, pending ar and probe hits
	always_ff @(posedge clk) begin
		if (rst) begin
			exp_ready <= 1'b0;
			ar_waiting <= 1'b0;
			probe_hits <= 0;
		end else begin
			exp_ready <= hit && !flush;
			ar_waiting <= arvalid && !arready;
			probe_hits <= probing ? probe_hits + int'(first && hit) : 0;
		end
		ar_prev <= araddr;
		if (hit) begin
			acc_addr <= addr;
		end
	end

	a_reset: assert property (@(posedge clk) $fell(rst) |-> !ready && !arvalid && !hit)
		else begin
			errors++;
			$display("FAIL %0t ready/arvalid/hit expected 0/0/0 got %b/%b/%b", $time,
				$sampled(ready), $sampled(arvalid), $sampled(hit));
		end
	a_inst: assert property (@(posedge clk) disable iff (rst)
		ready |-> inst == code_word(acc_addr))
		else begin
			errors++;
			$display("FAIL %0t inst expected %h got %h", $time,
				code_word($sampled(acc_addr)), $sampled(inst));
		end
	a_ready: assert property (@(posedge clk) disable iff (rst) ready == exp_ready)
		else begin
			errors++;
			$display("FAIL %0t ready expected %b got %b", $time, $sampled(exp_ready),
				$sampled(ready));
		end
	a_flush: assert property (@(posedge clk) disable iff (rst) hit && flush |=> !ready)
		else begin
			errors++;
			$display("FAIL %0t ready expected 0 got 1 after a flush", $time);
		end
	a_must_hit: assert property (@(posedge clk) disable iff (rst)
		first && expect_mode == mode_hit |-> hit && !arvalid)
		else begin
			errors++;
			$display("FAIL %0t hit/arvalid expected 1/0 got %b/%b", $time, $sampled(hit),
				$sampled(arvalid));
		end
	a_must_miss: assert property (@(posedge clk) disable iff (rst)
		first && expect_mode == mode_miss |-> arvalid && !hit)
		else begin
			errors++;
			$display("FAIL %0t arvalid/hit expected 1/0 got %b/%b", $time, $sampled(arvalid),
				$sampled(hit));
		end
	// 64-byte aligned line address
	a_araddr: assert property (@(posedge clk) disable iff (rst)
		arvalid |-> araddr == {addr[31:6], 6'b0})
		else begin
			errors++;
			$display("FAIL %0t araddr expected %h got %h", $time,
				{$sampled(addr[31:6]), 6'b0}, $sampled(araddr));
		end
	a_ar_held: assert property (@(posedge clk) disable iff (rst)
		ar_waiting |-> arvalid && araddr == ar_prev)
		else begin
			errors++;
			$display("FAIL %0t arvalid/araddr expected 1/%h got %b/%h", $time,
				$sampled(ar_prev), $sampled(arvalid), $sampled(araddr));
		end
	// refill beats are never held off
	a_rready: assert property (@(posedge clk) disable iff (rst) rready)
		else begin
			errors++;
			$display("FAIL %0t rready expected 1 got %b", $time, $sampled(rready));
		end
	a_set_capacity: assert property (@(posedge clk) disable iff (rst)
		probe_done |-> probe_hits <= num_ways)
		else begin
			errors++;
			$display("more lines of one set hit than the cache has ways (%0d hits)",
				$sampled(probe_hits));
		end

	// hold one fetch until ready and then release it
	task automatic fetch(input logic [31:0] a, input int mode);
		int n;
		n = 0;
		addr = a;
		valid = 1'b1;
		first = 1'b1;
		expect_mode = mode;
		@(posedge clk);
		#5;
		first = 1'b0;
		while (!ready && n < fetch_limit) begin
			@(posedge clk);
			#5;
			n++;
		end
		valid = 1'b0;
		expect_mode = mode_any;
		if (!ready) begin
			timed_out = 1'b1;
			$display("timeout, no answer from the cache for address %h", a);
		end
	endtask

	// fetch accepted and flushed in the same cycle gets no answer
	task automatic flushed_fetch(input logic [31:0] a);
		addr = a;
		valid = 1'b1;
		flush = 1'b1;
		first = 1'b1;
		expect_mode = mode_hit;
		@(posedge clk);
		#5;
		valid = 1'b0;
		flush = 1'b0;
		first = 1'b0;
		expect_mode = mode_any;
		@(posedge clk);
		#5;
	endtask

	task automatic pulse_inval(input logic [31:0] a);
		inval_addr = a;
		inval = 1'b1;
		@(posedge clk);
		#5;
		inval = 1'b0;
	endtask

	task automatic cold_miss_and_hits();
		fetch(32'h8000_1234, mode_miss);
		if (timed_out) return;
		fetch(32'h8000_1234, mode_hit);
		fetch(32'h8000_1200, mode_hit);
		fetch(32'h8000_123c, mode_hit);
	endtask

	// every word of two lines with the second walked from its last word
	task automatic word_select();
		for (int k = 0; k < 16; k++) begin
			fetch(32'h0000_2000 + 32'(k * 4), k == 0 ? mode_miss : mode_hit);
			if (timed_out) return;
		end
		for (int k = 15; k >= 0; k--) begin
			fetch(32'h0004_3a80 + 32'(k * 4), k == 15 ? mode_miss : mode_hit);
			if (timed_out) return;
		end
	endtask

	// fill five lines of set 5 and refetch them all while counting hits
	task automatic eviction();
		for (int k = 0; k < 5; k++) begin
			fetch(32'h0001_0140 + 32'(k * 32'h400) + 32'(k * 8), mode_miss);
			if (timed_out) return;
		end
		probing = 1'b1;
		for (int k = 0; k < 5; k++) begin
			fetch(32'h0001_0140 + 32'(k * 32'h400) + 32'(k * 8), mode_any);
			if (timed_out) return;
		end
		probe_done = 1'b1;
		@(posedge clk);
		#5;
		probe_done = 1'b0;
		probing = 1'b0;
	endtask

	task automatic inval_and_flush();
		// other tag in the same set leaves the line alone
		pulse_inval(32'h7000_1208);
		fetch(32'h8000_1220, mode_hit);
		pulse_inval(32'h8000_1208);
		fetch(32'h8000_1220, mode_miss);
		if (timed_out) return;
		flushed_fetch(32'h8000_1224);
		fetch(32'h8000_1224, mode_hit);
		// clear set 5 in all ways
		for (int k = 0; k < 5; k++) begin
			pulse_inval(32'h0001_0140 + 32'(k * 32'h400));
		end
		fetch(32'h0001_0950, mode_miss);
	endtask

	initial begin
		rst = 1'b1;
		addr = '0;
		valid = 1'b0;
		flush = 1'b0;
		inval = 1'b0;
		inval_addr = '0;
		first = 1'b0;
		expect_mode = mode_any;
		probing = 1'b0;
		probe_done = 1'b0;
		repeat (10) @(posedge clk);
		#5;
		rst = 1'b0;
		@(posedge clk);
		#5;
		cold_miss_and_hits();
		if (!timed_out) word_select();
		if (!timed_out) eviction();
		if (!timed_out) inval_and_flush();
		// give the last answer time to reach the checks
		repeat (2) @(posedge clk);
		$display("check errors %0d, memory model errors %0d, timeouts %0d",
			errors, mem_errors, timed_out);
		if (timed_out || errors != 0 || mem_errors != 0) begin
			$display("test failed");
		end else begin
			$display("test passed");
		end
		$finish;
	end

endmodule

//--- all.f
src/icache_pkg.sv
src/sram_port_if.sv
src/line_sram.sv
src/tag_store.sv
src/refill_ctrl.sv
src/hit_return.sv
src/icache.sv
test/axi_mem_model.sv
test/icache_tb.sv

//--- build.sh
#!/usr/bin/env bash
# compile the icache testbench with verilator, run it, check the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert --top-module icache_tb -f all.f -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

# a run that stopped early never printed its verdict
grep -q "test passed" sim.log
echo "simulation clean"
